/* core_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core settings
// Data widths, register file size and the RV32I
// opcode and funct3 encodings used by decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define REG_COUNT   32

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct3 codes of the ALU groups
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

/* core_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core package
// Instruction word views, ALU operation codes and
// the operand source select shared by forwarding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

package core_pkg;

	// R-type layout, register-register group
	typedef struct packed {
		logic [6:0]             funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} rType_t;

	// I-type layout, register-immediate group
	typedef struct packed {
		logic [11:0]            imm;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} iType_t;

	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instrWord_u;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASSB
	} aluOp_e;

	// Freshest value of one source register, x0 is always zero
	function automatic logic [`XLEN-1:0] pickOperand(
		input logic [`REG_ADDR_W-1:0] addr,
		input logic [`XLEN-1:0]       rfData,
		input logic                   exWrite,
		input logic [`REG_ADDR_W-1:0] exRd,
		input logic [`XLEN-1:0]       exResult,
		input logic                   wbWrite,
		input logic [`REG_ADDR_W-1:0] wbRd,
		input logic [`XLEN-1:0]       wbData
	);
		if (addr == '0)
			return '0;
		else if (exWrite && exRd == addr)
			return exResult;
		else if (wbWrite && wbRd == addr)
			return wbData;
		else
			return rfData;
	endfunction

endpackage

/* RegFile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// x1..x31 with two async read ports and one write
// port, x0 reads as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

module RegFile (
	input  logic                   clk,
	input  logic                   i_rstN,
	input  logic [`REG_ADDR_W-1:0] i_rAddr1,
	input  logic [`REG_ADDR_W-1:0] i_rAddr2,
	output logic [`XLEN-1:0]       o_rData1,
	output logic [`XLEN-1:0]       o_rData2,
	input  logic                   i_wEn,
	input  logic [`REG_ADDR_W-1:0] i_wAddr,
	input  logic [`XLEN-1:0]       i_wData
);
	// Only x1 upward has storage
	logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wEn && i_wAddr != '0) begin
			regs[i_wAddr] <= i_wData;
		end
	end

	// Reads see the old value in the write cycle, forwarding covers it
	assign o_rData1 = (i_rAddr1 == '0) ? '0 : regs[i_rAddr1];
	assign o_rData2 = (i_rAddr2 == '0) ? '0 : regs[i_rAddr2];

	noZeroWrite: assert property (@(posedge clk) disable iff (!i_rstN)
		i_wEn |-> i_wAddr != '0);

endmodule

/* ForwardUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand forwarding
// Picks each decode source from execute, writeback
// or the register file, newest first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

module ForwardUnit import core_pkg::*; (
	input  logic [`REG_ADDR_W-1:0] i_rs1Addr,
	input  logic [`REG_ADDR_W-1:0] i_rs2Addr,
	input  logic [`XLEN-1:0]       i_rfRs1Data,
	input  logic [`XLEN-1:0]       i_rfRs2Data,
	input  logic                   i_exWrite,
	input  logic [`REG_ADDR_W-1:0] i_exRd,
	input  logic [`XLEN-1:0]       i_exResult,
	input  logic                   i_wbWrite,
	input  logic [`REG_ADDR_W-1:0] i_wbRd,
	input  logic [`XLEN-1:0]       i_wbData,
	output logic [`XLEN-1:0]       o_rs1Data,
	output logic [`XLEN-1:0]       o_rs2Data
);
	// Execute result is one instruction newer than writeback
	assign o_rs1Data = pickOperand(i_rs1Addr, i_rfRs1Data,
		i_exWrite, i_exRd, i_exResult,
		i_wbWrite, i_wbRd, i_wbData);

	assign o_rs2Data = pickOperand(i_rs2Addr, i_rfRs2Data,
		i_exWrite, i_exRd, i_exResult,
		i_wbWrite, i_wbRd, i_wbData);

endmodule

/* Decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Maps an RV32I ALU instruction to an ALU op and
// operands, then loads the decode-to-execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

module Decode import core_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rstN,
	input  logic                   i_instrValid,
	input  logic [`XLEN-1:0]       i_instr,
	input  logic [`XLEN-1:0]       i_rs1Data,
	input  logic [`XLEN-1:0]       i_rs2Data,
	output logic [`REG_ADDR_W-1:0] o_rs1Addr,
	output logic [`REG_ADDR_W-1:0] o_rs2Addr,
	output logic                   o_exValid,
	output logic                   o_exWrite,
	output logic [`REG_ADDR_W-1:0] o_exRd,
	output aluOp_e                 o_exAluOp,
	output logic [`XLEN-1:0]       o_exOpA,
	output logic [`XLEN-1:0]       o_exOpB
);
	instrWord_u       instr;
	logic             isOp;
	logic             altBit;
	logic             supported;
	aluOp_e           aluOp;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] opB;

	assign instr     = i_instr;
	assign o_rs1Addr = instr.rType.rs1;
	assign o_rs2Addr = instr.rType.rs2;

	assign isOp = (instr.rType.opcode == `OPC_OP);
	// Bit 30 selects SUB and SRA, seen as funct7 or as immediate
	assign altBit = isOp ? instr.rType.funct7[5] : instr.iType.imm[10];

	assign immI = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
	// U-type immediate spans the I-type imm, rs1 and funct3 fields
	assign immU = {instr.iType.imm, instr.iType.rs1, instr.iType.funct3, 12'b0};

	always_comb begin
		case (instr.rType.funct3)
			`F3_ADD:  aluOp = (isOp && altBit) ? SUB : ADD;
			`F3_SLL:  aluOp = SLL;
			`F3_SLT:  aluOp = SLT;
			`F3_SLTU: aluOp = SLTU;
			`F3_XOR:  aluOp = XOR;
			`F3_SR:   aluOp = altBit ? SRA : SRL;
			`F3_OR:   aluOp = OR;
			default:  aluOp = AND;
		endcase
		supported = 1'b1;
		opB       = i_rs2Data;
		case (instr.rType.opcode)
			`OPC_OP: begin
				opB = i_rs2Data;
			end
			`OPC_OP_IMM: begin
				opB = immI;
			end
			`OPC_LUI: begin
				opB   = immU;
				aluOp = PASSB;
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_exValid <= 1'b0;
			o_exWrite <= 1'b0;
			o_exRd    <= '0;
			o_exAluOp <= ADD;
			o_exOpA   <= '0;
			o_exOpB   <= '0;
		end else begin
			o_exValid <= i_instrValid;
			// No write for x0 or an opcode outside the ALU groups
			o_exWrite <= i_instrValid & supported & (instr.rType.rd != '0);
			o_exRd    <= instr.rType.rd;
			o_exAluOp <= aluOp;
			o_exOpA   <= i_rs1Data;
			o_exOpB   <= opB;
		end
	end

	exValidKnown: assert property (@(posedge clk) disable iff (!i_rstN)
		!$isunknown(o_exValid));

endmodule

/* Execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// RV32I ALU plus the execute-to-writeback register
// that feeds the retire port and register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

module Execute import core_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rstN,
	input  logic                   i_exValid,
	input  logic                   i_exWrite,
	input  logic [`REG_ADDR_W-1:0] i_exRd,
	input  aluOp_e                 i_exAluOp,
	input  logic [`XLEN-1:0]       i_exOpA,
	input  logic [`XLEN-1:0]       i_exOpB,
	output logic [`XLEN-1:0]       o_exResult,
	output logic                   o_wbValid,
	output logic [`REG_ADDR_W-1:0] o_wbRd,
	output logic [`XLEN-1:0]       o_wbData
);
	logic [4:0]       shamt;
	logic             ltSigned;
	logic             ltUnsigned;
	logic [`XLEN-1:0] aluResult;

	assign shamt      = i_exOpB[4:0];
	assign ltSigned   = $signed(i_exOpA) < $signed(i_exOpB);
	assign ltUnsigned = i_exOpA < i_exOpB;

	always_comb begin
		case (i_exAluOp)
			ADD:     aluResult = i_exOpA + i_exOpB;
			SUB:     aluResult = i_exOpA - i_exOpB;
			SLL:     aluResult = i_exOpA << shamt;
			SLT:     aluResult = {{(`XLEN-1){1'b0}}, ltSigned};
			SLTU:    aluResult = {{(`XLEN-1){1'b0}}, ltUnsigned};
			XOR:     aluResult = i_exOpA ^ i_exOpB;
			SRL:     aluResult = i_exOpA >> shamt;
			SRA:     aluResult = $signed(i_exOpA) >>> shamt;
			OR:      aluResult = i_exOpA | i_exOpB;
			AND:     aluResult = i_exOpA & i_exOpB;
			// LUI, operand B already holds the upper immediate
			PASSB:   aluResult = i_exOpB;
			default: aluResult = '0;
		endcase
	end

	// Seen by forwarding in the same cycle
	assign o_exResult = aluResult;

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_wbValid <= 1'b0;
		end else begin
			o_wbValid <= i_exValid & i_exWrite;
		end
	end

	always_ff @(posedge clk) begin
		o_wbRd   <= i_exRd;
		o_wbData <= aluResult;
	end

	// Decode must have filtered x0 destinations two stages back
	retireRdNonZero: assert property (@(posedge clk) disable iff (!i_rstN)
		o_wbValid |-> o_wbRd != '0);

endmodule

/* Core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top
// Three-stage decode, execute and writeback integer
// pipeline with a retire port for every write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

module Core import core_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rstN,
	input  logic                   i_instrValid,
	input  logic [`XLEN-1:0]       i_instr,
	output logic                   o_wbValid,
	output logic [`REG_ADDR_W-1:0] o_wbRd,
	output logic [`XLEN-1:0]       o_wbData
);
	logic [`REG_ADDR_W-1:0] rs1Addr;
	logic [`REG_ADDR_W-1:0] rs2Addr;
	logic [`XLEN-1:0]       rfRs1Data;
	logic [`XLEN-1:0]       rfRs2Data;
	logic [`XLEN-1:0]       fwdRs1Data;
	logic [`XLEN-1:0]       fwdRs2Data;

	// Execute stage registers
	logic                   exValid;
	logic                   exWrite;
	logic [`REG_ADDR_W-1:0] exRd;
	aluOp_e                 exAluOp;
	logic [`XLEN-1:0]       exOpA;
	logic [`XLEN-1:0]       exOpB;
	logic [`XLEN-1:0]       exResult;

	Decode i_Decode (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_instrValid (i_instrValid),
		.i_instr      (i_instr),
		.i_rs1Data    (fwdRs1Data),
		.i_rs2Data    (fwdRs2Data),
		.o_rs1Addr    (rs1Addr),
		.o_rs2Addr    (rs2Addr),
		.o_exValid    (exValid),
		.o_exWrite    (exWrite),
		.o_exRd       (exRd),
		.o_exAluOp    (exAluOp),
		.o_exOpA      (exOpA),
		.o_exOpB      (exOpB)
	);

	RegFile i_RegFile (
		.clk      (clk),
		.i_rstN   (i_rstN),
		.i_rAddr1 (rs1Addr),
		.i_rAddr2 (rs2Addr),
		.o_rData1 (rfRs1Data),
		.o_rData2 (rfRs2Data),
		.i_wEn    (o_wbValid),
		.i_wAddr  (o_wbRd),
		.i_wData  (o_wbData)
	);

	ForwardUnit i_ForwardUnit (
		.i_rs1Addr   (rs1Addr),
		.i_rs2Addr   (rs2Addr),
		.i_rfRs1Data (rfRs1Data),
		.i_rfRs2Data (rfRs2Data),
		.i_exWrite   (exWrite),
		.i_exRd      (exRd),
		.i_exResult  (exResult),
		.i_wbWrite   (o_wbValid),
		.i_wbRd      (o_wbRd),
		.i_wbData    (o_wbData),
		.o_rs1Data   (fwdRs1Data),
		.o_rs2Data   (fwdRs2Data)
	);

	Execute i_Execute (
		.clk        (clk),
		.i_rstN     (i_rstN),
		.i_exValid  (exValid),
		.i_exWrite  (exWrite),
		.i_exRd     (exRd),
		.i_exAluOp  (exAluOp),
		.i_exOpA    (exOpA),
		.i_exOpB    (exOpB),
		.o_exResult (exResult),
		.o_wbValid  (o_wbValid),
		.o_wbRd     (o_wbRd),
		.o_wbData   (o_wbData)
	);

endmodule

/* tb_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core testbench
// Streams golden instructions into the pipeline and
// checks every retirement in order against the file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_settings.svh"

module tb_core;

	logic                   clk;
	logic                   i_rstN;
	logic                   i_instrValid;
	logic [`XLEN-1:0]       i_instr;
	logic                   o_wbValid;
	logic [`REG_ADDR_W-1:0] o_wbRd;
	logic [`XLEN-1:0]       o_wbData;

	// Golden stream, one entry per file line
	logic [`XLEN-1:0]       goldInstr [$];
	int                     goldRd    [$];
	logic [`XLEN-1:0]       goldData  [$];

	// Expected retirements, oldest at the front
	logic [`REG_ADDR_W-1:0] expRdQ    [$];
	logic [`XLEN-1:0]       expDataQ  [$];

	logic [`REG_ADDR_W-1:0] headRd;
	logic [`XLEN-1:0]       headData;
	int                     cycleCount      = 0;
	int                     cycleLimit      = 0;
	int                     retiredCount    = 0;

	Core i_dut (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_instrValid (i_instrValid),
		.i_instr      (i_instr),
		.o_wbValid    (o_wbValid),
		.o_wbRd       (o_wbRd),
		.o_wbData     (o_wbData)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("Error at time %0t: %s", $time, reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	// Lines that do not parse as three fields are comments or blank
	task automatic loadGolden();
		int               fd;
		int               fields;
		string            line;
		logic [`XLEN-1:0] instr;
		int               rd;
		logic [`XLEN-1:0] value;
		fd = $fopen("core_golden.txt", "r");
		if (fd == 0) begin
			abortRun("could not open core_golden.txt for reading");
		end else begin
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%h %d %h", instr, rd, value);
				if (fields == 3) begin
					goldInstr.push_back(instr);
					goldRd.push_back(rd);
					goldData.push_back(value);
				end
			end
			$fclose(fd);
			$display("Loaded %0d instructions from core_golden.txt", goldInstr.size());
		end
	endtask

	// Cycle budget covers reset, worst-case gaps and the drain
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit != 0 && cycleCount > cycleLimit) begin
			abortRun($sformatf("timeout after %0d cycles, retirements stopped arriving",
				cycleLimit));
		end
	end

	// Outputs sampled mid-cycle where they are stable
	always @(negedge clk) begin
		if (i_rstN === 1'b1 && o_wbValid === 1'b1) begin
			if (expRdQ.size() == 0) begin
				abortRun($sformatf("x%0d retired with no instruction waiting to retire",
					o_wbRd));
			end else begin
				headRd   = expRdQ.pop_front();
				headData = expDataQ.pop_front();
				retiredCount++;
				checkValue($sformatf("retirement %0d rd", retiredCount),
					32'(o_wbRd), 32'(headRd));
				checkValue($sformatf("retirement %0d data", retiredCount),
					o_wbData, headData);
			end
		end
	end

	initial begin
		int gap;
		void'($urandom(59));
		i_rstN       = 1'b0;
		i_instrValid = 1'b0;
		i_instr      = '0;

		loadGolden();
		if (goldInstr.size() == 0) begin
			abortRun("core_golden.txt holds no instructions");
		end
		cycleLimit = 4 * goldInstr.size() + 20;

		repeat (5) @(posedge clk);
		#1;
		i_rstN = 1'b1;

		for (int i = 0; i < goldInstr.size(); i++) begin
			i_instrValid = 1'b1;
			i_instr      = goldInstr[i];
			// rd zero marks an instruction that must not retire
			if (goldRd[i] != 0) begin
				expRdQ.push_back(`REG_ADDR_W'(goldRd[i]));
				expDataQ.push_back(goldData[i]);
			end
			@(posedge clk);
			#1;
			i_instrValid = 1'b0;
			i_instr      = '0;
			// Idle gap of 0 to 2 cycles
			gap = int'($urandom % 3);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end

		// Last retirement lands two cycles after its strobe, the rest catch strays
		repeat (4) @(posedge clk);

		if (expRdQ.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abortRun("expected retirements still pending at end of run");
		end
	end

endmodule

/* core_golden.txt */
// Columns: instruction (hex), expected rd (decimal), expected rd value (hex)
// rd 0 means the instruction must not retire
00500093  1 00000005
ffd00113  2 fffffffd
00012193  3 00000001
00513213  4 00000000
0f00c293  5 000000f5
1000e313  6 00000105
7f017393  7 000007f0
01f09413  8 80000000
00415493  9 0fffffff
40115513 10 fffffffe
41f45593 11 ffffffff
00208633 12 00000002
402086b3 13 00000008
00b09733 14 80000000
001127b3 15 00000001
00113833 16 00000000
005148b3 17 ffffff08
00b45933 18 00000001
40b459b3 19 ffffffff
00736a33 20 000007f5
0098fab3 21 0fffff08
12345b37 22 12345000
fffffbb7 23 fffff000
678b0c13 24 12345678
018c0cb3 25 2468acf0
418c8d33 26 12345678
018d4db3 27 00000000
001d8d93 27 00000001
01bc1e33 28 2468acf0
06400093  1 00000064
00108093  1 00000065
00008eb3 29 00000065
00708013  0 00000000
00100f33 30 00000065
0000af83  0 00000000
00001f97  0 00000000
000feeb3 29 00000000
01e03e33 28 00000001
0025a1b3  3 00000000
40cbd213  4 ffffffff

/* list.f */
+incdir+.
core_pkg.sv
RegFile.sv
ForwardUnit.sv
Decode.sv
Execute.sv
Core.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator, pass only on the pass line
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_core -f list.f -o Vtb_core \
	&& ./obj_dir/Vtb_core > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"

[ -f sim.log ] && cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
